// File: hw/mlpLayerPkg.sv
`default_nettype none

package mlpLayerPkg;

	localparam int NUM_INPUTS = 10;
	localparam int NUM_NEURONS = 4;
	localparam int DATA_WIDTH = 16;
	localparam int ADDR_WIDTH = 6;
	localparam int BUS_WIDTH = 32;
	localparam int LEVEL_WIDTH = 3;
	localparam int FRAMES_WIDTH = 8;

	typedef logic signed [DATA_WIDTH-1:0] activation_t;
	typedef activation_t [NUM_INPUTS-1:0] frame_t;
	typedef activation_t [NUM_INPUTS-1:0] weightSet_t;
	typedef weightSet_t [NUM_NEURONS-1:0] layerWeights_t;
	typedef activation_t [NUM_NEURONS-1:0] layerBias_t;

	// word addresses of the Wishbone register map
	localparam logic [ADDR_WIDTH-1:0] ADDR_ACT_BASE = ADDR_WIDTH'(0);
	localparam logic [ADDR_WIDTH-1:0] ADDR_COMMIT = ADDR_WIDTH'(10);
	localparam logic [ADDR_WIDTH-1:0] ADDR_STATUS = ADDR_WIDTH'(10);
	localparam logic [ADDR_WIDTH-1:0] ADDR_ACK = ADDR_WIDTH'(11);
	localparam logic [ADDR_WIDTH-1:0] ADDR_RESULT_BASE = ADDR_WIDTH'(16);

	typedef struct packed {
		logic [BUS_WIDTH-DATA_WIDTH-1:0] unused;
		activation_t value;
	} actView_t;

	typedef struct packed {
		logic resultReady;
		logic [LEVEL_WIDTH-1:0] fifoLevel;
		logic [FRAMES_WIDTH-1:0] framesDone;
		logic [BUS_WIDTH-1-LEVEL_WIDTH-FRAMES_WIDTH-1:0] unused;
	} statusView_t;

	// the same bus word carries either one activation or the status fields
	typedef union packed {
		actView_t act;
		statusView_t status;
	} wbWord_t;

	// each set is listed from input 9 down to input 0, neuron 3 first
	localparam layerWeights_t DEFAULT_WEIGHTS = '{
		'{-16'sd30, 16'sd6, -16'sd26, 16'sd3, -16'sd11, 16'sd37, -16'sd4, -16'sd17, 16'sd12,
			16'sd8},
		'{-16'sd1, 16'sd19, -16'sd28, 16'sd14, 16'sd5, -16'sd22, 16'sd9, -16'sd6, 16'sd30,
			-16'sd15},
		'{16'sd11, -16'sd3, 16'sd27, -16'sd9, 16'sd18, 16'sd4, -16'sd35, 16'sd21, -16'sd7,
			16'sd13},
		'{16'sd0, -16'sd52, -16'sd2, 16'sd48, 16'sd26, 16'sd32, -16'sd20, 16'sd2, -16'sd20,
			-16'sd24}
	};

	localparam layerBias_t DEFAULT_BIAS = '{16'sd7, 16'sd25, -16'sd40, 16'sd0};

endpackage

`default_nettype wire

// File: hw/wbFrameLoader.sv
`default_nettype none

module wbFrameLoader (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [mlpLayerPkg::ADDR_WIDTH-1:0] adr,
	input logic [mlpLayerPkg::BUS_WIDTH-1:0] datIn,
	input logic pushFull,
	output logic ack,
	output logic [mlpLayerPkg::BUS_WIDTH-1:0] datOut,
	output logic pushValid,
	output mlpLayerPkg::frame_t pushFrame,
	output logic resultAck,
	input logic [mlpLayerPkg::LEVEL_WIDTH-1:0] fifoLevel,
	input logic resultReady,
	input mlpLayerPkg::activation_t [mlpLayerPkg::NUM_NEURONS-1:0] results,
	input logic [mlpLayerPkg::FRAMES_WIDTH-1:0] framesDone
);

	localparam int ACT_SEL_WIDTH = $clog2(mlpLayerPkg::NUM_INPUTS);
	localparam int RESULT_SEL_WIDTH = $clog2(mlpLayerPkg::NUM_NEURONS);

	mlpLayerPkg::wbWord_t writeWord;
	mlpLayerPkg::wbWord_t readWord;
	mlpLayerPkg::frame_t frameReg;
	logic [mlpLayerPkg::ADDR_WIDTH-1:0] actOffset;
	logic [mlpLayerPkg::ADDR_WIDTH-1:0] resultOffset;
	logic request;
	logic actWrite;
	logic commitReq;
	logic ackReq;

	assign writeWord = datIn;
	assign actOffset = adr - mlpLayerPkg::ADDR_ACT_BASE;
	assign resultOffset = adr - mlpLayerPkg::ADDR_RESULT_BASE;

	// a new request is only seen while no ack is out, so each access acks once
	assign request = cyc && stb && !ack;
	assign actWrite = request && we &&
		actOffset < mlpLayerPkg::ADDR_WIDTH'(mlpLayerPkg::NUM_INPUTS);
	assign commitReq = request && we && adr == mlpLayerPkg::ADDR_COMMIT;
	assign ackReq = request && we && adr == mlpLayerPkg::ADDR_ACK;

	assign pushFrame = frameReg;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ack <= 1'b0;
			pushValid <= 1'b0;
			resultAck <= 1'b0;
		end
		else
		begin
			// a commit into a full FIFO waits here with ack low
			ack <= request && !(commitReq && pushFull);
			pushValid <= commitReq && !pushFull;
			resultAck <= ackReq;
		end
	end

	always_ff @(posedge clk)
	begin
		if (actWrite)
		begin
			frameReg[actOffset[ACT_SEL_WIDTH-1:0]] <= writeWord.act.value;
		end
	end

	always_comb
	begin
		readWord = '0;
		if (adr == mlpLayerPkg::ADDR_STATUS)
		begin
			readWord.status.resultReady = resultReady;
			readWord.status.fifoLevel = fifoLevel;
			readWord.status.framesDone = framesDone;
		end
		else if (resultOffset < mlpLayerPkg::ADDR_WIDTH'(mlpLayerPkg::NUM_NEURONS))
		begin
			readWord.act.value = results[resultOffset[RESULT_SEL_WIDTH-1:0]];
		end
	end

	// read data is registered so it lines up with ack
	always_ff @(posedge clk)
	begin
		if (request)
		begin
			datOut <= readWord;
		end
	end

endmodule

`default_nettype wire

// File: hw/frameFifo.sv
`default_nettype none

module frameFifo #(
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic reset,
	input logic pushValid,
	input mlpLayerPkg::frame_t pushFrame,
	output logic full,
	input logic popReady,
	output logic popValid,
	output mlpLayerPkg::frame_t popFrame,
	output logic [mlpLayerPkg::LEVEL_WIDTH-1:0] level
);

	localparam int PTR_WIDTH = DEPTH > 1 ? $clog2(DEPTH) : 1;
	localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

	mlpLayerPkg::frame_t mem [DEPTH];
	logic [PTR_WIDTH-1:0] wrPtr;
	logic [PTR_WIDTH-1:0] rdPtr;
	logic [COUNT_WIDTH-1:0] count;
	logic doPush;
	logic doPop;

	function automatic logic [PTR_WIDTH-1:0] nextPtr(input logic [PTR_WIDTH-1:0] ptr);
		if (ptr == PTR_WIDTH'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full = count == COUNT_WIDTH'(DEPTH);
	assign popValid = count != '0;
	assign popFrame = mem[rdPtr];
	assign level = mlpLayerPkg::LEVEL_WIDTH'(count);

	assign doPush = pushValid && !full;
	assign doPop = popValid && popReady;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			// simultaneous push and pop leaves the count alone
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= pushFrame;
	end

endmodule

`default_nettype wire

// File: hw/neuronRelu.sv
`default_nettype none

module neuronRelu #(
	parameter mlpLayerPkg::weightSet_t WEIGHTS = mlpLayerPkg::DEFAULT_WEIGHTS[0],
	parameter mlpLayerPkg::activation_t BIAS = mlpLayerPkg::DEFAULT_BIAS[0]
) (
	input logic clk,
	input logic reset,
	input mlpLayerPkg::frame_t inputs,
	output mlpLayerPkg::activation_t activation
);

	mlpLayerPkg::frame_t inputsReg;
	mlpLayerPkg::activation_t sumNext;
	mlpLayerPkg::activation_t sumReg;

	// every product and partial sum keeps only the low 16 bits
	always_comb
	begin
		sumNext = BIAS;
		for (int i = 0; i < mlpLayerPkg::NUM_INPUTS; i++)
		begin
			sumNext = sumNext + mlpLayerPkg::activation_t'(inputsReg[i] * WEIGHTS[i]);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputsReg <= '0;
			sumReg <= '0;
			activation <= '0;
		end
		else
		begin
			inputsReg <= inputs;
			sumReg <= sumNext;
			// negative sums are clamped to zero
			if (sumReg[mlpLayerPkg::DATA_WIDTH-1])
				activation <= '0;
			else
				activation <= sumReg;
		end
	end

endmodule

`default_nettype wire

// File: hw/layerEngine.sv
`default_nettype none

module layerEngine #(
	parameter mlpLayerPkg::layerWeights_t WEIGHTS = mlpLayerPkg::DEFAULT_WEIGHTS,
	parameter mlpLayerPkg::layerBias_t BIAS = mlpLayerPkg::DEFAULT_BIAS
) (
	input logic clk,
	input logic reset,
	input logic popValid,
	input mlpLayerPkg::frame_t popFrame,
	output logic popReady,
	input logic resultAck,
	output logic resultReady,
	output mlpLayerPkg::activation_t [mlpLayerPkg::NUM_NEURONS-1:0] results,
	output logic [mlpLayerPkg::FRAMES_WIDTH-1:0] framesDone
);

	mlpLayerPkg::activation_t [mlpLayerPkg::NUM_NEURONS-1:0] neuronOut;

	// one bit per neuron pipeline stage, set for the frame being computed
	logic [2:0] inFlight;

	// only one frame is ever in the neurons, and only while the bank is free
	assign popReady = popValid && !resultReady && inFlight == 3'b000;

	// the neurons see the head frame directly and latch it on the pop edge
	generate
		for (genvar n = 0; n < mlpLayerPkg::NUM_NEURONS; n++)
		begin : gNeuron
			neuronRelu #(
				.WEIGHTS(WEIGHTS[n]),
				.BIAS(BIAS[n])
			) neuron_i (
				.clk(clk),
				.reset(reset),
				.inputs(popFrame),
				.activation(neuronOut[n])
			);
		end
	endgenerate

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inFlight <= 3'b000;
			resultReady <= 1'b0;
			framesDone <= '0;
		end
		else
		begin
			inFlight <= {inFlight[1:0], popReady};
			if (inFlight[2])
			begin
				resultReady <= 1'b1;
				framesDone <= framesDone + 1'b1;
			end
			else if (resultAck)
			begin
				resultReady <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (inFlight[2])
			results <= neuronOut;
	end

endmodule

`default_nettype wire

// File: hw/mlpLayerTop.sv
`default_nettype none

module mlpLayerTop #(
	parameter int DEPTH = 4,
	parameter mlpLayerPkg::layerWeights_t WEIGHTS = mlpLayerPkg::DEFAULT_WEIGHTS,
	parameter mlpLayerPkg::layerBias_t BIAS = mlpLayerPkg::DEFAULT_BIAS
) (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [mlpLayerPkg::ADDR_WIDTH-1:0] adr,
	input logic [mlpLayerPkg::BUS_WIDTH-1:0] datIn,
	output logic [mlpLayerPkg::BUS_WIDTH-1:0] datOut,
	output logic ack
);

	logic pushValid;
	mlpLayerPkg::frame_t pushFrame;
	logic pushFull;
	logic [mlpLayerPkg::LEVEL_WIDTH-1:0] fifoLevel;
	logic popValid;
	mlpLayerPkg::frame_t popFrame;
	logic popReady;
	logic resultAck;
	logic resultReady;
	mlpLayerPkg::activation_t [mlpLayerPkg::NUM_NEURONS-1:0] results;
	logic [mlpLayerPkg::FRAMES_WIDTH-1:0] framesDone;

	wbFrameLoader loader_i (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.pushFull(pushFull),
		.ack(ack),
		.datOut(datOut),
		.pushValid(pushValid),
		.pushFrame(pushFrame),
		.resultAck(resultAck),
		.fifoLevel(fifoLevel),
		.resultReady(resultReady),
		.results(results),
		.framesDone(framesDone)
	);

	frameFifo #(
		.DEPTH(DEPTH)
	) fifo_i (
		.clk(clk),
		.reset(reset),
		.pushValid(pushValid),
		.pushFrame(pushFrame),
		.full(pushFull),
		.popReady(popReady),
		.popValid(popValid),
		.popFrame(popFrame),
		.level(fifoLevel)
	);

	layerEngine #(
		.WEIGHTS(WEIGHTS),
		.BIAS(BIAS)
	) engine_i (
		.clk(clk),
		.reset(reset),
		.popValid(popValid),
		.popFrame(popFrame),
		.popReady(popReady),
		.resultAck(resultAck),
		.resultReady(resultReady),
		.results(results),
		.framesDone(framesDone)
	);

endmodule

`default_nettype wire

// File: tb/tbClockGen.sv
`default_nettype none

module tbClockGen #(
	parameter int PERIOD = 8
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

// File: tb/mlpLayer_assert.sv
`default_nettype none

module mlpLayerAssert (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic ack,
	input logic pushValid,
	input logic pushFull,
	input logic resultReady,
	input logic [mlpLayerPkg::LEVEL_WIDTH-1:0] fifoLevel,
	input logic [mlpLayerPkg::FRAMES_WIDTH-1:0] framesDone
);

	int failCount = 0;

	ackOneCycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
		else
		begin
			failCount++;
			$error("ack stayed high for more than one cycle");
		end

	ackNeedsRequest: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> $past(cyc && stb))
		else
		begin
			failCount++;
			$error("ack rose without cyc and stb in the cycle before");
		end

	// registers cleared by a reset cycle show up on the following edge
	clearAfterReset: assert property (@(posedge clk)
		reset |=> !ack && !resultReady && fifoLevel == '0 && framesDone == '0)
		else
		begin
			failCount++;
			$error("ack, resultReady or status not clear after reset");
		end

	noPushWhenFull: assert property (@(posedge clk) disable iff (reset)
		pushValid |-> !pushFull)
		else
		begin
			failCount++;
			$error("frame pushed while the FIFO was full");
		end

endmodule

bind mlpLayerTop mlpLayerAssert assert_i (
	.clk(clk),
	.reset(reset),
	.cyc(cyc),
	.stb(stb),
	.ack(ack),
	.pushValid(pushValid),
	.pushFull(pushFull),
	.resultReady(resultReady),
	.fifoLevel(fifoLevel),
	.framesDone(framesDone)
);

`default_nettype wire

// File: tb/mlpLayerTb.sv
`default_nettype none

module mlpLayerTb;

	localparam int NUM_FRAMES = 8;
	localparam int FRAME_CYCLES = 150;
	localparam int MARGIN_CYCLES = 200;
	localparam int STALL_LIMIT = 20;
	localparam int NO_LIMIT = 1000;

	logic clk;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [mlpLayerPkg::ADDR_WIDTH-1:0] adr;
	logic [mlpLayerPkg::BUS_WIDTH-1:0] datIn;
	logic [mlpLayerPkg::BUS_WIDTH-1:0] datOut;
	logic ack;
	int valueErrors;
	int otherErrors;
	logic [mlpLayerPkg::FRAMES_WIDTH-1:0] doneCount;
	mlpLayerPkg::frame_t pending[$];

	tbClockGen #(.PERIOD(8)) clock_i (.clk(clk));

	mlpLayerTop dut_i (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.datOut(datOut),
		.ack(ack)
	);

	// wrapped products and sums, then ReLU
	function automatic mlpLayerPkg::activation_t modelNeuron(input mlpLayerPkg::frame_t f,
		input int n);
		logic signed [31:0] product;
		logic [15:0] acc;
		acc = mlpLayerPkg::DEFAULT_BIAS[n];
		for (int i = 0; i < mlpLayerPkg::NUM_INPUTS; i++)
		begin
			product = 32'(f[i]) * 32'(mlpLayerPkg::DEFAULT_WEIGHTS[n][i]);
			acc = acc + product[15:0];
		end
		return acc[15] ? '0 : acc;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			valueErrors++;
			$display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
		end
	endtask

	// outputs are sampled on the falling edge, away from the DUT's updates
	task automatic busCycle(input logic write, input logic [mlpLayerPkg::ADDR_WIDTH-1:0] a,
		input logic [31:0] d, input int maxWaits, output logic [31:0] rdata, output logic acked);
		int waits;
		waits = 0;
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= write;
		adr <= a;
		datIn <= d;
		@(negedge clk);
		while (!ack && waits < maxWaits)
		begin
			waits++;
			@(negedge clk);
		end
		rdata = datOut;
		acked = ack;
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
	endtask

	task automatic wbWrite(input logic [mlpLayerPkg::ADDR_WIDTH-1:0] a, input logic [31:0] d);
		logic [31:0] unusedData;
		logic acked;
		busCycle(1'b1, a, d, NO_LIMIT, unusedData, acked);
	endtask

	task automatic wbRead(input logic [mlpLayerPkg::ADDR_WIDTH-1:0] a, output logic [31:0] d);
		logic acked;
		busCycle(1'b0, a, '0, NO_LIMIT, d, acked);
	endtask

	task automatic randomFrame(output mlpLayerPkg::frame_t f);
		for (int i = 0; i < mlpLayerPkg::NUM_INPUTS; i++)
			f[i] = mlpLayerPkg::activation_t'(int'($urandom_range(400)) - 200);
	endtask

	task automatic writeFrame(input mlpLayerPkg::frame_t f);
		mlpLayerPkg::wbWord_t word;
		for (int i = 0; i < mlpLayerPkg::NUM_INPUTS; i++)
		begin
			word = '0;
			word.act.value = f[i];
			wbWrite(mlpLayerPkg::ADDR_ACT_BASE + mlpLayerPkg::ADDR_WIDTH'(i), word);
		end
	endtask

	task automatic commitFrame(input mlpLayerPkg::frame_t f);
		writeFrame(f);
		wbWrite(mlpLayerPkg::ADDR_COMMIT, '0);
		pending.push_back(f);
	endtask

	// waits for the oldest committed frame, checks it and frees the result bank
	task automatic finishFrame();
		mlpLayerPkg::wbWord_t word;
		mlpLayerPkg::wbWord_t expected;
		mlpLayerPkg::frame_t f;
		f = pending.pop_front();
		do
		begin
			wbRead(mlpLayerPkg::ADDR_STATUS, word);
		end
		while (!word.status.resultReady);
		doneCount++;
		checkValue("framesDone", 32'(doneCount), 32'(word.status.framesDone));
		for (int n = 0; n < mlpLayerPkg::NUM_NEURONS; n++)
		begin
			wbRead(mlpLayerPkg::ADDR_RESULT_BASE + mlpLayerPkg::ADDR_WIDTH'(n), word);
			expected = '0;
			expected.act.value = modelNeuron(f, n);
			checkValue($sformatf("results[%0d]", n), expected, word);
		end
		wbWrite(mlpLayerPkg::ADDR_ACK, '0);
		wbRead(mlpLayerPkg::ADDR_STATUS, word);
		checkValue("resultReady", 32'd0, 32'(word.status.resultReady));
	endtask

	initial
	begin
		mlpLayerPkg::wbWord_t word;
		mlpLayerPkg::frame_t f;
		logic [31:0] unusedData;
		logic acked;
		void'($urandom(32'h65f9));
		valueErrors = 0;
		otherErrors = 0;
		doneCount = '0;
		reset <= 1'b1;
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
		adr <= '0;
		datIn <= '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		wbRead(mlpLayerPkg::ADDR_STATUS, word);
		checkValue("status", 32'd0, word);

		// a frame and its negation push each neuron's sum to both signs
		randomFrame(f);
		commitFrame(f);
		finishFrame();
		for (int i = 0; i < mlpLayerPkg::NUM_INPUTS; i++)
			f[i] = -f[i];
		commitFrame(f);
		finishFrame();

		for (int i = 0; i < mlpLayerPkg::NUM_INPUTS; i++)
			f[i] = (i % 2 == 0) ? 16'sh7fff : -16'sh7ff0;
		commitFrame(f);

		// with that result unacked, four frames fill the FIFO and the next commit stalls
		repeat (4)
		begin
			randomFrame(f);
			commitFrame(f);
		end
		randomFrame(f);
		writeFrame(f);
		busCycle(1'b1, mlpLayerPkg::ADDR_COMMIT, '0, STALL_LIMIT, unusedData, acked);
		assert (!acked)
		else
		begin
			otherErrors++;
			$display("a commit into the full FIFO was acked without wait states");
		end
		wbRead(mlpLayerPkg::ADDR_STATUS, word);
		checkValue("fifoLevel", 32'd4, 32'(word.status.fifoLevel));
		finishFrame();
		wbWrite(mlpLayerPkg::ADDR_COMMIT, '0);
		pending.push_back(f);
		repeat (5) finishFrame();

		$display("value errors: %0d, other errors: %0d, assertion errors: %0d", valueErrors,
			otherErrors, dut_i.assert_i.failCount);
		if (valueErrors + otherErrors + dut_i.assert_i.failCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial
	begin
		repeat (NUM_FRAMES * FRAME_CYCLES + MARGIN_CYCLES) @(posedge clk);
		$display("timeout: the run did not finish in %0d cycles",
			NUM_FRAMES * FRAME_CYCLES + MARGIN_CYCLES);
		$display("value errors: %0d, other errors: %0d, assertion errors: %0d", valueErrors,
			otherErrors, dut_i.assert_i.failCount);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: mlpLayer.f
hw/mlpLayerPkg.sv
hw/wbFrameLoader.sv
hw/frameFifo.sv
hw/neuronRelu.sv
hw/layerEngine.sv
hw/mlpLayerTop.sv
tb/tbClockGen.sv
tb/mlpLayer_assert.sv
tb/mlpLayerTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mlpLayerTb -f mlpLayer.f -o mlpLayerSim
./obj_dir/mlpLayerSim | tee sim.log

if grep -q "Simulation failed" sim.log; then
	echo "run.sh: testbench reported failure"
	exit 1
fi
echo "run.sh: no failure found in sim.log"
